/* project.f */
+incdir+logic
logic/rayCorePkg.sv
logic/rasterHitIf.sv
logic/primitiveWalker.sv
logic/closestHit.sv
logic/rasterUnit.sv
logic/shaderUnit.sv
logic/rayCore.sv
test/clockGen.sv
test/rayCoreTb.sv

/* test/rayCoreTb.sv */
`include "rayCore_settings.svh"

module rayCoreTb
    import rayCorePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic resetn;
    logic rayValid;
    coordT rayX;
    coordT rayY;
    primIndexT groupStart;
    primIndexT groupCount;
    logic primHit [`UNIT_SIZE];
    depthT primDepth [`UNIT_SIZE];
    colorT primColor [`UNIT_SIZE];
    colorT clearColor;
    logic outFull;
    logic rayFull;
    primIndexT startPrimitive;
    primIndexT endPrimitive;
    logic outValid;
    coordT outX;
    coordT outY;
    logic outHit;
    primIndexT outPrimIndex;
    colorT outColor;

    // primitive memory contents per index
    logic tblHit [256];
    depthT tblDepth [256];
    colorT tblColor [256];

    pixelOut expectQ [$];
    primIndexT startQ [$];
    primIndexT endQ [$];
    int seed = 31552;
    int sentCount = 0;
    int cycleCount = 0;
    logic stallOn = 1'b0;
    logic lastRayFull = 1'b0;

    clockGen clocks (
        .clk(clk),
        .resetn(resetn)
    );

    rayCore rayCore_inst (
        .clk(clk),
        .resetn(resetn),
        .rayValid(rayValid),
        .rayX(rayX),
        .rayY(rayY),
        .groupStart(groupStart),
        .groupCount(groupCount),
        .primHit(primHit),
        .primDepth(primDepth),
        .primColor(primColor),
        .clearColor(clearColor),
        .outFull(outFull),
        .rayFull(rayFull),
        .startPrimitive(startPrimitive),
        .endPrimitive(endPrimitive),
        .outValid(outValid),
        .outX(outX),
        .outY(outY),
        .outHit(outHit),
        .outPrimIndex(outPrimIndex),
        .outColor(outColor)
    );

    // --------------------
    // expected pixel by a linear scan over the real group
    function automatic pixelOut expectPixel(input rayInput ray, input colorT clear);
        pixelOut px;
        primIndexT idx;
        depthT nearest;
        px = '{x: ray.x, y: ray.y, hit: 1'b0, primIndex: '0, color: clear};
        nearest = '0;
        for (int i = 0; i < ray.groupCount; i++) begin
            idx = ray.groupStart + primIndexT'(i);
            if (tblHit[idx] && (!px.hit || (tblDepth[idx] < nearest))) begin
                px.hit = 1'b1;
                px.primIndex = idx;
                px.color = tblColor[idx];
                nearest = tblDepth[idx];
            end
        end
        return px;
    endfunction

    function automatic rayInput makeRay(input coordT x, input coordT y,
            input primIndexT start, input primIndexT count);
        return '{x: x, y: y, groupStart: start, groupCount: count};
    endfunction

    // groups stay below index 192 so no window wraps
    function automatic rayInput randomRay();
        int draw;
        int place;
        draw = $random(seed);
        place = $random(seed);
        return '{x: coordT'(draw), y: coordT'(draw >> 16),
                 groupStart: {1'b0, place[6:0]}, groupCount: {2'b0, place[13:8]}};
    endfunction

    // --------------------
    // failure reporting
    task automatic stopWithFail();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportValue(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        stopWithFail();
    endtask

    task automatic checkPixel(input pixelOut got, input pixelOut exp);
        if (got.x !== exp.x) reportValue("outX", 32'(got.x), 32'(exp.x));
        if (got.y !== exp.y) reportValue("outY", 32'(got.y), 32'(exp.y));
        if (got.hit !== exp.hit) reportValue("outHit", 32'(got.hit), 32'(exp.hit));
        if (got.color !== exp.color) reportValue("outColor", 32'(got.color), 32'(exp.color));
        // index is only meaningful on a hit
        if (exp.hit && (got.primIndex !== exp.primIndex)) begin
            reportValue("outPrimIndex", 32'(got.primIndex), 32'(exp.primIndex));
        end
    endtask

    task automatic checkIndex(input string name, input primIndexT got, input primIndexT exp);
        if (got !== exp) reportValue(name, 32'(got), 32'(exp));
    endtask

    // --------------------
    // stimulus helpers that run on the falling edge
    task automatic driveWindow();
        primIndexT idx;
        for (int k = 0; k < `UNIT_SIZE; k++) begin
            idx = startPrimitive + primIndexT'(k);
            primHit[k] = tblHit[idx];
            primDepth[k] = tblDepth[idx];
            primColor[k] = tblColor[idx];
        end
    endtask

    task automatic nextCycle();
        int draw;
        @(negedge clk);
        driveWindow();
        draw = $random(seed);
        outFull = stallOn && (draw[2:0] < 3'd3);
    endtask

    task automatic setPrim(input primIndexT idx, input logic hit, input depthT depth,
            input colorT color);
        tblHit[idx] = hit;
        tblDepth[idx] = depth;
        tblColor[idx] = color;
    endtask

    task automatic sendRay(input rayInput ray);
        while (rayFull) nextCycle();
        rayValid = 1'b1;
        rayX = ray.x;
        rayY = ray.y;
        groupStart = ray.groupStart;
        groupCount = ray.groupCount;
        // free slot takes the ray on the coming rising edge
        expectQ.push_back(expectPixel(ray, clearColor));
        startQ.push_back(ray.groupStart);
        endQ.push_back(ray.groupStart + ray.groupCount);
        sentCount++;
        nextCycle();
        rayValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (expectQ.size() != 0) nextCycle();
    endtask

    // --------------------
    initial begin : stimulus
        int draw;
        int padEnd;
        int counts [5];
        rayValid = 1'b0;
        rayX = '0;
        rayY = '0;
        groupStart = '0;
        groupCount = '0;
        clearColor = 24'h203040;
        outFull = 1'b0;
        for (int k = 0; k < `UNIT_SIZE; k++) begin
            primHit[k] = 1'b0;
            primDepth[k] = '0;
            primColor[k] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            draw = $random(seed);
            tblHit[i] = draw[0];
            tblDepth[i] = draw[31:16];
            tblColor[i] = colorT'($random(seed));
        end
        while (!resetn) nextCycle();
        nextCycle();
        if ((rayFull !== 1'b0) || (outValid !== 1'b0)) begin
            $display("rayFull or outValid not low after reset");
            stopWithFail();
        end

        // nearest of several hits in a 4 wide and an unaligned 8 wide group
        setPrim(16, 1'b1, 16'h0500, 24'h110000);
        setPrim(17, 1'b1, 16'h0200, 24'h220000);
        setPrim(18, 1'b0, 16'h0010, 24'h330000);
        setPrim(19, 1'b1, 16'h0300, 24'h440000);
        sendRay(makeRay(10'd1, 10'd2, 8'd16, 8'd4));
        for (int i = 41; i < 49; i++) begin
            setPrim(primIndexT'(i), 1'b1, 16'h0400 + depthT'(i), colorT'(i) * 24'h010101);
        end
        setPrim(44, 1'b1, 16'h0080, 24'h00aa00);
        setPrim(46, 1'b1, 16'h0080, 24'h0000bb);
        setPrim(47, 1'b0, 16'h0001, 24'hcc0000);
        sendRay(makeRay(10'd3, 10'd4, 8'd41, 8'd8));
        waitDrain();

        // no hit at all and then an empty group with tempting padding
        for (int i = 100; i < 106; i++) begin
            setPrim(primIndexT'(i), 1'b0, 16'h0040, 24'h808080);
        end
        setPrim(106, 1'b1, 16'h0000, 24'hffffff);
        setPrim(107, 1'b1, 16'h0000, 24'hffffff);
        sendRay(makeRay(10'd5, 10'd6, 8'd100, 8'd6));
        for (int i = 110; i < 114; i++) begin
            setPrim(primIndexT'(i), 1'b1, 16'h0000, 24'hffffff);
        end
        sendRay(makeRay(10'd7, 10'd8, 8'd110, 8'd0));
        waitDrain();

        // padding slots hit at depth 0 and must be ignored
        counts = '{1, 2, 3, 5, 7};
        for (int n = 0; n < 5; n++) begin
            padEnd = counts[n] + `UNIT_SIZE - 1;
            padEnd = padEnd - (padEnd % `UNIT_SIZE);
            for (int i = counts[n]; i < padEnd; i++) begin
                setPrim(primIndexT'(140 + 12 * n + i), 1'b1, 16'h0000, 24'hfefefe);
            end
            sendRay(makeRay(10'(n), 10'd9, primIndexT'(140 + 12 * n), primIndexT'(counts[n])));
            waitDrain();
        end

        // back to back random stream
        for (int n = 0; n < 40; n++) begin
            sendRay(randomRay());
        end
        waitDrain();

        // same again with the sink stalling on random cycles
        stallOn = 1'b1;
        for (int n = 0; n < 40; n++) begin
            sendRay(randomRay());
        end
        waitDrain();
        stallOn = 1'b0;
        repeat (10) nextCycle();

        if ((expectQ.size() == 0) && (endQ.size() == 0)) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("rays still outstanding at the end of the run");
            stopWithFail();
        end
    end

    // --------------------
    // compare the values seen just before each rising edge
    always @(posedge clk) begin : compare
        pixelOut got;
        pixelOut exp;
        if (resetn) begin
            if (outValid && outFull) begin
                $display("outValid was raised while outFull was high");
                stopWithFail();
            end else if (outValid && (expectQ.size() == 0)) begin
                $display("a pixel came out with no ray waiting for it");
                stopWithFail();
            end else if (outValid) begin
                got = '{x: outX, y: outY, hit: outHit, primIndex: outPrimIndex, color: outColor};
                exp = expectQ.pop_front();
                checkPixel(got, exp);
            end
            // walker loaded on the previous edge as the slot emptied
            if (lastRayFull && !rayFull) begin
                if (endQ.size() == 0) begin
                    $display("a ray was loaded that was never sent");
                    stopWithFail();
                end else begin
                    checkIndex("startPrimitive", startPrimitive, startQ.pop_front());
                    checkIndex("endPrimitive", endPrimitive, endQ.pop_front());
                end
            end
            lastRayFull = rayFull;
        end
    end

    // limit grows with each ray sent
    always @(posedge clk) begin : watchdog
        cycleCount++;
        if (cycleCount > 200 * sentCount + 100) begin
            $display("timeout after %0d cycles with %0d rays sent", cycleCount, sentCount);
            stopWithFail();
        end
    end

endmodule

/* test/clockGen.sv */
module clockGen (
    output logic clk,
    output logic resetn
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // two cycles of reset, released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

/* logic/rayCore.sv */
`include "rayCore_settings.svh"

module rayCore import rayCorePkg::*; (
    input logic clk,
    input logic resetn,
    input logic rayValid,
    input coordT rayX,
    input coordT rayY,
    input primIndexT groupStart,
    input primIndexT groupCount,
    input logic primHit [`UNIT_SIZE],
    input depthT primDepth [`UNIT_SIZE],
    input colorT primColor [`UNIT_SIZE],
    input colorT clearColor,
    input logic outFull,
    output logic rayFull,
    output primIndexT startPrimitive,
    output primIndexT endPrimitive,
    output logic outValid,
    output coordT outX,
    output coordT outY,
    output logic outHit,
    output primIndexT outPrimIndex,
    output colorT outColor
);

    rayInput rayIn;
    pixelOut pixel;

    rasterHitIf link ();

    assign rayIn = '{x: rayX, y: rayY, groupStart: groupStart, groupCount: groupCount};

    // --------------------
    // raster then shade
    rasterUnit raster (
        .clk(clk),
        .resetn(resetn),
        .rayValid(rayValid),
        .rayIn(rayIn),
        .rayFull(rayFull),
        .startPrimitive(startPrimitive),
        .endPrimitive(endPrimitive),
        .primHit(primHit),
        .primDepth(primDepth),
        .primColor(primColor),
        .link(link.raster)
    );

    shaderUnit shader (
        .clk(clk),
        .resetn(resetn),
        .link(link.shader),
        .clearColor(clearColor),
        .outFull(outFull),
        .outValid(outValid),
        .pixel(pixel)
    );

    assign outX = pixel.x;
    assign outY = pixel.y;
    assign outHit = pixel.hit;
    assign outPrimIndex = pixel.primIndex;
    assign outColor = pixel.color;

endmodule

/* logic/shaderUnit.sv */
`include "rayCore_settings.svh"

module shaderUnit import rayCorePkg::*; (
    input logic clk,
    input logic resetn,
    rasterHitIf.shader link,
    input colorT clearColor,
    input logic outFull,
    output logic outValid,
    output pixelOut pixel
);

    shaderState state;
    rayInput bufRay;
    hitRecord bufRec;
    logic captureRecord;
    logic takeRecord;

    assign captureRecord = link.valid && !link.full;
    assign takeRecord = (state == SHADE_IDLE) && link.full;

    // pixel leaves only in a cycle where the sink has room
    assign outValid = (state == SHADE_DONE) && !outFull;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            link.full <= 1'b0;
            state <= SHADE_IDLE;
        end else begin
            if (captureRecord) begin
                link.full <= 1'b1;
            end else if (takeRecord) begin
                link.full <= 1'b0;
            end
            case (state)
                SHADE_IDLE: begin
                    if (takeRecord) begin
                        state <= SHADE_DONE;
                    end
                end
                SHADE_DONE: begin
                    if (!outFull) begin
                        state <= SHADE_IDLE;
                    end
                end
                default: begin
                    state <= SHADE_IDLE;
                end
            endcase
        end
    end

    // one-entry buffer and the shaded pixel
    always_ff @(posedge clk) begin
        if (captureRecord) begin
            bufRay <= link.ray;
            bufRec <= link.rec;
        end
        if (takeRecord) begin
            pixel.x <= bufRay.x;
            pixel.y <= bufRay.y;
            pixel.hit <= bufRec.hit;
            pixel.primIndex <= bufRec.primIndex;
            // clear color when nothing was hit
            pixel.color <= bufRec.hit ? bufRec.color : clearColor;
        end
    end

endmodule

/* logic/rasterUnit.sv */
`include "rayCore_settings.svh"

module rasterUnit import rayCorePkg::*; (
    input logic clk,
    input logic resetn,
    input logic rayValid,
    input rayInput rayIn,
    output logic rayFull,
    output primIndexT startPrimitive,
    output primIndexT endPrimitive,
    input logic primHit [`UNIT_SIZE],
    input depthT primDepth [`UNIT_SIZE],
    input colorT primColor [`UNIT_SIZE],
    rasterHitIf.raster link
);

    rasterState state;
    rayInput slotRay;
    rayInput curRay;
    logic loadRay;
    logic walkStep;
    logic windowOpen;
    hitRecord best;

    assign loadRay = (state == RAST_INIT) && rayFull;
    assign walkStep = (state == RAST_WALK) && windowOpen;

    // --------------------
    // input slot
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rayFull <= 1'b0;
        end else if (!rayFull && rayValid) begin
            rayFull <= 1'b1;
        end else if (loadRay) begin
            rayFull <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rayFull && rayValid) begin
            slotRay <= rayIn;
        end
        if (loadRay) begin
            curRay <= slotRay;
        end
    end

    // --------------------
    // raster fsm
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= RAST_INIT;
        end else begin
            case (state)
                RAST_INIT: begin
                    if (rayFull) begin
                        state <= RAST_WALK;
                    end
                end
                // one closing cycle after the last window
                RAST_WALK: begin
                    if (!windowOpen) begin
                        state <= RAST_DONE;
                    end
                end
                RAST_DONE: begin
                    if (!link.full) begin
                        state <= RAST_INIT;
                    end
                end
                default: begin
                    state <= RAST_INIT;
                end
            endcase
        end
    end

    primitiveWalker walker (
        .clk(clk),
        .resetn(resetn),
        .load(loadRay),
        .group(slotRay),
        .step(walkStep),
        .startPrimitive(startPrimitive),
        .endPrimitive(endPrimitive),
        .lastStep(),
        .windowOpen(windowOpen)
    );

    closestHit reduce (
        .clk(clk),
        .resetn(resetn),
        .clear(loadRay),
        .sample(walkStep),
        .startPrimitive(startPrimitive),
        .endPrimitive(endPrimitive),
        .primHit(primHit),
        .primDepth(primDepth),
        .primColor(primColor),
        .best(best)
    );

    // hand-over strobe, leaves RAST_DONE on the same edge
    assign link.valid = (state == RAST_DONE) && !link.full;
    assign link.ray = curRay;
    assign link.rec = best;

endmodule

/* logic/closestHit.sv */
`include "rayCore_settings.svh"

module closestHit import rayCorePkg::*; (
    input logic clk,
    input logic resetn,
    input logic clear,
    input logic sample,
    input primIndexT startPrimitive,
    input primIndexT endPrimitive,
    input logic primHit [`UNIT_SIZE],
    input depthT primDepth [`UNIT_SIZE],
    input colorT primColor [`UNIT_SIZE],
    output hitRecord best
);

    primIndexT slotsLeft;
    logic winHit;
    primIndexT winIndex;
    depthT winDepth;
    colorT winColor;

    logic bestHit;
    primIndexT bestIndex;
    depthT bestDepth;
    colorT bestColor;

    // slots of this window that still belong to the group
    assign slotsLeft = endPrimitive - startPrimitive;

    // nearest hit in the window, strict compare keeps the lower index on a tie
    always_comb begin
        winHit = 1'b0;
        winIndex = startPrimitive;
        winDepth = '0;
        winColor = '0;
        for (int k = 0; k < `UNIT_SIZE; k++) begin
            if (primHit[k] && (primIndexT'(k) < slotsLeft)
                    && (!winHit || (primDepth[k] < winDepth))) begin
                winHit = 1'b1;
                winIndex = startPrimitive + primIndexT'(k);
                winDepth = primDepth[k];
                winColor = primColor[k];
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            bestHit <= 1'b0;
        end else if (clear) begin
            bestHit <= 1'b0;
        end else if (sample && winHit) begin
            bestHit <= 1'b1;
        end
    end

    // earlier windows hold lower indices so a tie keeps the stored record
    always_ff @(posedge clk) begin
        if (!clear && sample && winHit && (!bestHit || (winDepth < bestDepth))) begin
            bestIndex <= winIndex;
            bestDepth <= winDepth;
            bestColor <= winColor;
        end
    end

    assign best = '{hit: bestHit, primIndex: bestIndex, depth: bestDepth, color: bestColor};

endmodule

/* logic/primitiveWalker.sv */
`include "rayCore_settings.svh"

module primitiveWalker import rayCorePkg::*; (
    input logic clk,
    input logic resetn,
    input logic load,
    input rayInput group,
    input logic step,
    output primIndexT startPrimitive,
    output primIndexT endPrimitive,
    output logic lastStep,
    output logic windowOpen
);

    // one extra bit so the aligned end of a group near the top does not wrap
    typedef logic [`PRIM_INDEX_WIDTH:0] wideIndexT;

    wideIndexT cursor;
    wideIndexT alignedEnd;
    wideIndexT nextCursor;
    wideIndexT roundedCount;
    wideIndexT alignedCount;

    // count rounded up to whole windows
    assign roundedCount = {1'b0, group.groupCount} + wideIndexT'(`UNIT_SIZE - 1);
    assign alignedCount = (roundedCount >> `UNIT_SIZE_WIDTH) << `UNIT_SIZE_WIDTH;

    assign nextCursor = cursor + wideIndexT'(`UNIT_SIZE);
    assign lastStep = (nextCursor == alignedEnd);
    assign startPrimitive = cursor[`PRIM_INDEX_WIDTH-1:0];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cursor <= '0;
            alignedEnd <= '0;
            endPrimitive <= '0;
            windowOpen <= 1'b0;
        end else if (load) begin
            cursor <= {1'b0, group.groupStart};
            alignedEnd <= {1'b0, group.groupStart} + alignedCount;
            endPrimitive <= group.groupStart + group.groupCount;
            windowOpen <= (group.groupCount != '0);
        end else if (step && windowOpen) begin
            cursor <= nextCursor;
            // window closes once the final step is taken
            if (lastStep) begin
                windowOpen <= 1'b0;
            end
        end
    end

endmodule

/* logic/rasterHitIf.sv */
// hit record hand-over between the raster and shader stages
interface rasterHitIf;

    // one-cycle strobe, only raised while full is low
    logic valid;
    rayCorePkg::rayInput ray;
    rayCorePkg::hitRecord rec;
    // shader buffer occupied
    logic full;

    modport raster (
        output valid,
        output ray,
        output rec,
        input full
    );

    modport shader (
        input valid,
        input ray,
        input rec,
        output full
    );

endinterface

/* logic/rayCorePkg.sv */
package rayCorePkg;

`include "rayCore_settings.svh"

    typedef logic [`PRIM_INDEX_WIDTH-1:0] primIndexT;
    typedef logic [`DEPTH_WIDTH-1:0] depthT;
    typedef logic [`COLOR_WIDTH-1:0] colorT;
    typedef logic [`COORD_WIDTH-1:0] coordT;

    // --------------------
    // state machines
    typedef enum logic [1:0] {RAST_INIT, RAST_WALK, RAST_DONE} rasterState;
    typedef enum logic {SHADE_IDLE, SHADE_DONE} shaderState;

    // --------------------
    // records
    typedef struct packed {
        coordT x;
        coordT y;
        primIndexT groupStart;
        primIndexT groupCount;
    } rayInput;

    typedef struct packed {
        logic hit;
        primIndexT primIndex;
        depthT depth;
        colorT color;
    } hitRecord;

    typedef struct packed {
        coordT x;
        coordT y;
        logic hit;
        primIndexT primIndex;
        colorT color;
    } pixelOut;

endpackage

/* logic/rayCore_settings.svh */
`ifndef RAYCORE_SETTINGS_SVH
`define RAYCORE_SETTINGS_SVH

// primitive slots tested per walk step
`define UNIT_SIZE 4
// log2 of the unit size
`define UNIT_SIZE_WIDTH 2

// primitive index and group count
`define PRIM_INDEX_WIDTH 8

// hit distance, smaller is nearer
`define DEPTH_WIDTH 16

// packed rgb
`define COLOR_WIDTH 24

// pixel coordinates
`define COORD_WIDTH 10

`endif
